/* dv/tb_yurut_birimi.sv */
// Self-checking execute stage testbench running file vectors and seeded random R-type tests
`timescale 1ns/10ps

`include "amb_config.svh"

module tb_yurut_birimi;

    localparam int    RESET_CYCLES = 5;
    localparam int    RANDOM_TESTS = 64;
    localparam string STIM_FILE    = "dv/yurut_stim.txt";

    logic           clk_i = 1'b0;
    logic           rst_i;
    logic           gecerli_i;
    amb_pkg::veri_t buyruk_i;
    amb_pkg::veri_t rs1_i;
    amb_pkg::veri_t rs2_i;
    amb_pkg::veri_t pc_i;
    amb_pkg::veri_t sonuc_o;
    logic           gecerli_o;
    logic           hata_o;

    // Expected responses in strobe order
    amb_pkg::veri_t exp_sonuc_q [$];
    logic           exp_hata_q  [$];
    string          name_q      [$];

    // Vectors from the stimulus file
    amb_pkg::veri_t stim_buyruk [$];
    amb_pkg::veri_t stim_rs1    [$];
    amb_pkg::veri_t stim_rs2    [$];
    amb_pkg::veri_t stim_pc     [$];
    amb_pkg::veri_t stim_sonuc  [$];
    logic           stim_hata   [$];

    int   tests_run    = 0;
    int   tests_failed = 0;
    int   stray_errors = 0;  // Mismatches between tests
    int   cycle_limit  = 0;
    int   cycle_count  = 0;
    logic strobe_prev  = 1'b0;  // Strobe the DUT sampled on the last rising edge

    yurut_birimi yurut_birimi_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .gecerli_i (gecerli_i),
        .buyruk_i  (buyruk_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .pc_i      (pc_i),
        .sonuc_o   (sonuc_o),
        .gecerli_o (gecerli_o),
        .hata_o    (hata_o)
    );

    always #20 clk_i = ~clk_i;  // 40 ns period

    task automatic compare_word(input string sig, input amb_pkg::veri_t got,
                                input amb_pkg::veri_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Fail %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    task automatic compare_bit(input string sig, input logic got, input logic exp,
                               output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Fail %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    // RV32I register-register result
    function automatic amb_pkg::veri_t reference_result(input logic [2:0] f3, input logic alt,
                                                        input amb_pkg::veri_t a,
                                                        input amb_pkg::veri_t b);
        logic [4:0]     sh;
        amb_pkg::veri_t r;
        sh = b[4:0];
        case (f3)
            `F3_ADD:  r = alt ? a - b : a + b;
            `F3_SLL:  r = a << sh;
            `F3_SLT:  r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            `F3_SLTU: r = {31'b0, a < b};
            `F3_XOR:  r = a ^ b;
            `F3_SR:   r = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            `F3_OR:   r = a | b;
            default:  r = a & b;
        endcase
        return r;
    endfunction

    task automatic load_stimulus(output bit ok);
        int             fd;
        int             code;
        string          line;
        amb_pkg::veri_t f_buyruk;
        amb_pkg::veri_t f_rs1;
        amb_pkg::veri_t f_rs2;
        amb_pkg::veri_t f_pc;
        amb_pkg::veri_t f_sonuc;
        amb_pkg::veri_t f_hata;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;  // Blank or comment line
            end
            code = $sscanf(line, "%h %h %h %h %h %h",
                           f_buyruk, f_rs1, f_rs2, f_pc, f_sonuc, f_hata);
            if (code == 6) begin
                stim_buyruk.push_back(f_buyruk);
                stim_rs1.push_back(f_rs1);
                stim_rs2.push_back(f_rs2);
                stim_pc.push_back(f_pc);
                stim_sonuc.push_back(f_sonuc);
                stim_hata.push_back(f_hata != 0);
            end
        end
        $fclose(fd);
        ok = (stim_buyruk.size() > 0);
    endtask

    task automatic send_instruction(input amb_pkg::veri_t buyruk, rs1, rs2, pc, exp_sonuc,
                                    input logic exp_hata, input string name);
        @(posedge clk_i);
        gecerli_i <= 1'b1;
        buyruk_i  <= buyruk;
        rs1_i     <= rs1;
        rs2_i     <= rs2;
        pc_i      <= pc;
        exp_sonuc_q.push_back(exp_sonuc);
        exp_hata_q.push_back(exp_hata);
        name_q.push_back(name);
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        gecerli_i <= 1'b0;
    endtask

    // Checks the outputs half a cycle after each rising edge
    always @(negedge clk_i) begin : response_check
        bit             ok_valid;
        bit             ok_word;
        bit             ok_flag;
        amb_pkg::veri_t exp_sonuc;
        logic           exp_hata;
        string          name;
        if (rst_i) begin
            strobe_prev = 1'b0;
        end else begin
            compare_bit("gecerli_o", gecerli_o, strobe_prev, ok_valid);
            if (strobe_prev && exp_sonuc_q.size() > 0) begin
                exp_sonuc = exp_sonuc_q.pop_front();
                exp_hata  = exp_hata_q.pop_front();
                name      = name_q.pop_front();
                compare_word("sonuc_o", sonuc_o, exp_sonuc, ok_word);
                compare_bit("hata_o", hata_o, exp_hata, ok_flag);
                tests_run++;
                if (ok_valid && ok_word && ok_flag) begin
                    $display("%s: ok", name);
                end else begin
                    tests_failed++;
                    $display("%s: failed", name);
                end
            end else if (strobe_prev) begin
                stray_errors++;
                $display("A strobe was sampled with no expected result left to compare");
            end else begin
                compare_bit("hata_o", hata_o, 1'b0, ok_flag);  // No flag without a result
                if (!ok_valid || !ok_flag) begin
                    stray_errors++;
                end
            end
            strobe_prev = gecerli_i;
        end
    end

    task automatic run_tests();
        amb_pkg::veri_t a;
        amb_pkg::veri_t b;
        amb_pkg::veri_t instr;
        logic [2:0]     f3;
        logic           alt;
        int unsigned    r;
        int             n;
        bit             ok_s;
        bit             ok_v;
        bit             ok_h;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        @(negedge clk_i);
        compare_word("sonuc_o", sonuc_o, '0, ok_s);
        compare_bit("gecerli_o", gecerli_o, 1'b0, ok_v);
        compare_bit("hata_o", hata_o, 1'b0, ok_h);
        tests_run++;
        if (ok_s && ok_v && ok_h) begin
            $display("reset values: ok");
        end else begin
            tests_failed++;
            $display("reset values: failed");
        end

        // File vectors back to back
        foreach (stim_buyruk[i]) begin
            send_instruction(stim_buyruk[i], stim_rs1[i], stim_rs2[i], stim_pc[i],
                             stim_sonuc[i], stim_hata[i],
                             $sformatf("file vector %0d (%h)", i + 1, stim_buyruk[i]));
        end
        idle_cycle();

        for (n = 0; n < RANDOM_TESTS; n++) begin
            r   = $urandom;
            f3  = r[2:0];
            alt = r[3] && (f3 == `F3_ADD || f3 == `F3_SR);
            a   = $urandom;
            b   = $urandom;
            if (r[6:5] == 2'b00) begin
                a = b ^ 32'h1;  // Nearly equal operands for the compares
            end
            instr = {1'b0, alt, 5'b0, r[12:8], r[17:13], f3, r[22:18], `OPC_OP};
            send_instruction(instr, a, b, $urandom, reference_result(f3, alt, a, b), 1'b0,
                             $sformatf("random %0d funct3 %0d%s", n, f3, alt ? " alt" : ""));
            if (r[31:30] == 2'b00) begin
                idle_cycle();  // Gap between strobes now and then
            end
        end
        idle_cycle();

        while (exp_sonuc_q.size() != 0) @(negedge clk_i);
        repeat (2) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    initial begin : main
        bit loaded;
        rst_i     <= 1'b1;
        gecerli_i <= 1'b0;
        buyruk_i  <= '0;
        rs1_i     <= '0;
        rs2_i     <= '0;
        pc_i      <= '0;
        void'($urandom(32'h8b55));
        load_stimulus(loaded);
        cycle_limit = 2 * (stim_buyruk.size() + RANDOM_TESTS + RESET_CYCLES) + 20;
        if (!loaded) begin
            $display("Could not read any vector from %s", STIM_FILE);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            run_tests();
            $display("Tests run %0d, failed %0d, other errors %0d",
                     tests_run, tests_failed, stray_errors);
            if (tests_failed == 0 && stray_errors == 0) begin
                $display("ALL TESTS PASSED");
            end else begin
                $display("SOME TESTS FAILED");
            end
            $finish;
        end
    end

    initial begin : watchdog
        @(posedge clk_i);
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the results did not all arrive", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* dv/yurut_stim.txt */
# Columns in hex: instruction rs1 rs2 pc expected_result expected_illegal
# Registers and pc that the instruction does not use hold filler values
002081b3 ffffffff 00000001 00000000 00000000 0
002081b3 12345678 0edcba98 00000000 21111110 0
002081b3 7fffffff 00000001 00000000 80000000 0
402081b3 00000000 00000001 00000000 ffffffff 0
402081b3 80000000 00000001 00000000 7fffffff 0
402081b3 00001234 00001234 00000000 00000000 0
00108193 ffffffff deadbeef 00000000 00000000 0
fff08193 00000000 deadbeef 00000000 ffffffff 0
00001197 55555555 deadbeef 00000100 00001100 0
fffff197 55555555 deadbeef 00002004 00001004 0
0020c1b3 f0f0f0f0 ff00ff00 00000000 0ff00ff0 0
0020e1b3 f0f0f0f0 0f0f0000 00000000 fffff0f0 0
0020f1b3 f0f0f0f0 ff00ff00 00000000 f000f000 0
fff0c193 12345678 deadbeef 00000000 edcba987 0
8000e193 00000001 deadbeef 00000000 fffff801 0
0f00f193 ffffffff deadbeef 00000000 000000f0 0
002091b3 00000001 0000003f 00000000 80000000 0
0020d1b3 80000000 00000024 00000000 08000000 0
4020d1b3 80000000 00000004 00000000 f8000000 0
4020d1b3 7ffffff0 00000004 00000000 07ffffff 0
00409193 0000000f deadbeef 00000000 000000f0 0
0080d193 f0000000 deadbeef 00000000 00f00000 0
4080d193 f0000000 deadbeef 00000000 fff00000 0
0020a1b3 ffffffff 00000001 00000000 00000001 0
0020b1b3 ffffffff 00000001 00000000 00000000 0
0020b1b3 00000005 00000007 00000000 00000001 0
fff0a193 00000000 deadbeef 00000000 00000000 0
fff0b193 00000000 deadbeef 00000000 00000001 0
123451b7 aaaaaaaa deadbeef 00000000 12345000 0
fffff1b7 aaaaaaaa deadbeef 00000000 fffff000 0
0000a183 12345678 87654321 00000040 00000000 1
022081b3 00000003 00000005 00000000 00000000 1
4020c1b3 f0f0f0f0 ff00ff00 00000000 00000000 1
40409193 0000000f deadbeef 00000000 00000000 1
0250d193 f0000000 deadbeef 00000000 00000000 1
ffffffff 11111111 22222222 00000080 00000000 1

/* list.f */
+incdir+rtl
rtl/amb_pkg.sv
rtl/toplayici.sv
rtl/aritmetik_mantik_birimi.sv
rtl/amb_kod_cozucu.sv
rtl/yurut_birimi.sv
dv/tb_yurut_birimi.sv

/* rtl/amb_config.svh */
// ALU control codes and RV32I opcode/funct3 values, included by decoder, ALU and testbench
`ifndef AMB_CONFIG_SVH
`define AMB_CONFIG_SVH

// ALU control codes, 4 bits wide
`define AMB_TOPLAMA 4'd0
`define AMB_CIKARMA 4'd1
`define AMB_XOR     4'd2
`define AMB_OR      4'd3
`define AMB_AND     4'd4
`define AMB_SLL     4'd5
`define AMB_SRL     4'd6
`define AMB_SRA     4'd7
`define AMB_SLT     4'd8
`define AMB_SLTU    4'd9
`define AMB_GECIR   4'd10  // Operand 2 passes straight through

// RV32I major opcodes handled by this stage
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// funct3 values shared by OP and OP-IMM
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // SRL or SRA, picked by funct7 bit 5
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

/* rtl/amb_kod_cozucu.sv */
// Decodes OP, OP-IMM, LUI and AUIPC into an ALU control code, immediate and operand selects
`timescale 1ns/10ps

`include "amb_config.svh"

module amb_kod_cozucu (
    input  amb_pkg::veri_t    buyruk_i,
    output amb_pkg::kontrol_t kontrol_o,
    output amb_pkg::veri_t    ivedi_o,
    output logic              imm_kullan_o,
    output logic              pc_kullan_o,
    output logic              gecersiz_o
);

    logic [6:0]     opkod;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           alt_islem;  // funct7 bit 5, selects SUB and SRA
    logic           diger_f7;   // Any funct7 bit apart from bit 5
    amb_pkg::veri_t i_ivedi;
    amb_pkg::veri_t u_ivedi;

    assign opkod     = buyruk_i[6:0];
    assign funct3    = buyruk_i[14:12];
    assign funct7    = buyruk_i[31:25];
    assign alt_islem = funct7[5];
    assign diger_f7  = |{funct7[6], funct7[4:0]};

    assign i_ivedi = {{20{buyruk_i[31]}}, buyruk_i[31:20]};
    assign u_ivedi = {buyruk_i[31:12], 12'b0};

    always_comb begin
        kontrol_o    = `AMB_TOPLAMA;
        ivedi_o      = i_ivedi;
        imm_kullan_o = 1'b0;
        pc_kullan_o  = 1'b0;
        gecersiz_o   = 1'b0;

        case (opkod)
            `OPC_OP: begin
                case (funct3)
                    `F3_ADD:  kontrol_o = alt_islem ? `AMB_CIKARMA : `AMB_TOPLAMA;
                    `F3_SLL:  kontrol_o = `AMB_SLL;
                    `F3_SLT:  kontrol_o = `AMB_SLT;
                    `F3_SLTU: kontrol_o = `AMB_SLTU;
                    `F3_XOR:  kontrol_o = `AMB_XOR;
                    `F3_SR:   kontrol_o = alt_islem ? `AMB_SRA : `AMB_SRL;
                    `F3_OR:   kontrol_o = `AMB_OR;
                    default:  kontrol_o = `AMB_AND;
                endcase
                // Bit 5 is only legal on add and right shift
                gecersiz_o = diger_f7 ||
                             (alt_islem && (funct3 != `F3_ADD) && (funct3 != `F3_SR));
            end

            `OPC_OP_IMM: begin
                imm_kullan_o = 1'b1;
                case (funct3)
                    `F3_ADD:  kontrol_o = `AMB_TOPLAMA;
                    `F3_SLL: begin
                        kontrol_o  = `AMB_SLL;
                        gecersiz_o = |funct7;
                    end
                    `F3_SLT:  kontrol_o = `AMB_SLT;
                    `F3_SLTU: kontrol_o = `AMB_SLTU;
                    `F3_XOR:  kontrol_o = `AMB_XOR;
                    `F3_SR: begin
                        kontrol_o  = alt_islem ? `AMB_SRA : `AMB_SRL;
                        gecersiz_o = diger_f7;
                    end
                    `F3_OR:   kontrol_o = `AMB_OR;
                    default:  kontrol_o = `AMB_AND;
                endcase
            end

            `OPC_LUI: begin
                kontrol_o    = `AMB_GECIR;  // Result is the immediate itself
                ivedi_o      = u_ivedi;
                imm_kullan_o = 1'b1;
            end

            `OPC_AUIPC: begin
                ivedi_o      = u_ivedi;
                imm_kullan_o = 1'b1;
                pc_kullan_o  = 1'b1;
            end

            default: gecersiz_o = 1'b1;
        endcase
    end

endmodule

/* rtl/amb_pkg.sv */
// Vector types shared by the execute stage RTL and its testbench
package amb_pkg;

    // Data word, used for operands, results, immediates, pc and instructions
    typedef logic [31:0] veri_t;

    // ALU control code
    typedef logic [3:0] kontrol_t;

    // Adder operand and sum, carry-in folded into bit 0
    typedef logic [32:0] toplam_t;

    // Shift amount taken from operand 2
    typedef logic [4:0] kaydirma_t;

endpackage

/* rtl/aritmetik_mantik_birimi.sv */
// Execute stage ALU, computes every candidate result and picks one by control code
`timescale 1ns/10ps

`include "amb_config.svh"

module aritmetik_mantik_birimi (
    input  amb_pkg::kontrol_t kontrol_i,
    input  amb_pkg::veri_t    deger1_i,
    input  amb_pkg::veri_t    deger2_i,
    output amb_pkg::veri_t    sonuc_o
);

    logic               cikarma;
    amb_pkg::kaydirma_t kaydirma;

    // Adder side
    amb_pkg::toplam_t   deger1_top;
    amb_pkg::toplam_t   deger2_top;
    amb_pkg::toplam_t   sonuc_top;

    // Logic, shift and compare side
    amb_pkg::veri_t     sonuc_xor;
    amb_pkg::veri_t     sonuc_or;
    amb_pkg::veri_t     sonuc_and;
    amb_pkg::veri_t     sonuc_sll;
    amb_pkg::veri_t     sonuc_srl;
    amb_pkg::veri_t     sonuc_sra;
    amb_pkg::veri_t     sonuc_slt;
    amb_pkg::veri_t     sonuc_sltu;

    assign cikarma  = (kontrol_i == `AMB_CIKARMA);
    assign kaydirma = deger2_i[4:0];

    // Subtract as a + ~b + 1, the +1 comes from both low bits set
    assign deger1_top = {deger1_i, cikarma};
    assign deger2_top = cikarma ? {~deger2_i, 1'b1} : {deger2_i, 1'b0};

    toplayici sklansky_toplayici (
        .a_i      (deger1_top),
        .b_i      (deger2_top),
        .toplam_o (sonuc_top)
    );

    assign sonuc_xor  = deger1_i ^ deger2_i;
    assign sonuc_or   = deger1_i | deger2_i;
    assign sonuc_and  = deger1_i & deger2_i;
    assign sonuc_sll  = deger1_i << kaydirma;
    assign sonuc_srl  = deger1_i >> kaydirma;
    assign sonuc_sra  = $signed(deger1_i) >>> kaydirma;  // Sign bit fills from the left
    assign sonuc_slt  = {31'b0, $signed(deger1_i) < $signed(deger2_i)};
    assign sonuc_sltu = {31'b0, deger1_i < deger2_i};

    always_comb begin
        case (kontrol_i)
            `AMB_TOPLAMA,
            `AMB_CIKARMA: sonuc_o = sonuc_top[32:1];
            `AMB_XOR:     sonuc_o = sonuc_xor;
            `AMB_OR:      sonuc_o = sonuc_or;
            `AMB_AND:     sonuc_o = sonuc_and;
            `AMB_SLL:     sonuc_o = sonuc_sll;
            `AMB_SRL:     sonuc_o = sonuc_srl;
            `AMB_SRA:     sonuc_o = sonuc_sra;
            `AMB_SLT:     sonuc_o = sonuc_slt;
            `AMB_SLTU:    sonuc_o = sonuc_sltu;
            `AMB_GECIR:   sonuc_o = deger2_i;
            default:      sonuc_o = '0;  // Unused codes
        endcase
    end

endmodule

/* rtl/toplayici.sv */
// Sklansky parallel-prefix adder for 33-bit operands, instantiated by the ALU
`timescale 1ns/10ps

module toplayici (
    input  amb_pkg::toplam_t a_i,
    input  amb_pkg::toplam_t b_i,
    output amb_pkg::toplam_t toplam_o
);

    localparam int GENISLIK = $bits(amb_pkg::toplam_t);
    localparam int SEVIYE   = $clog2(GENISLIK);  // 6 levels for 33 bits

    // Group generate and propagate per level, level 0 holds the bit values
    wire amb_pkg::toplam_t uret [0:SEVIYE];
    wire amb_pkg::toplam_t yay  [0:SEVIYE];

    assign uret[0] = a_i & b_i;
    assign yay[0]  = a_i ^ b_i;

    genvar s, i;

    generate
        for (s = 1; s <= SEVIYE; s++) begin : g_seviye
            // Block size doubles every level
            localparam int ARALIK = 1 << (s - 1);

            for (i = 0; i < GENISLIK; i++) begin : g_bit
                if ((i % (2 * ARALIK)) >= ARALIK) begin : g_birlestir
                    // Top bit of the lower half of this block
                    localparam int J = (i / (2 * ARALIK)) * (2 * ARALIK) + ARALIK - 1;

                    assign uret[s][i] = uret[s-1][i] | (yay[s-1][i] & uret[s-1][J]);
                    assign yay[s][i]  = yay[s-1][i] & yay[s-1][J];
                end else begin : g_gecir
                    assign uret[s][i] = uret[s-1][i];
                    assign yay[s][i]  = yay[s-1][i];
                end
            end
        end
    endgenerate

    // Carry into bit i is the prefix generate of bits i-1 down to 0
    assign toplam_o = yay[0] ^ {uret[SEVIYE][GENISLIK-2:0], 1'b0};

endmodule

/* rtl/yurut_birimi.sv */
// Integer execute stage top, decodes one instruction per strobe and registers the ALU result
`timescale 1ns/10ps

module yurut_birimi (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           gecerli_i,
    input  amb_pkg::veri_t buyruk_i,
    input  amb_pkg::veri_t rs1_i,
    input  amb_pkg::veri_t rs2_i,
    input  amb_pkg::veri_t pc_i,
    output amb_pkg::veri_t sonuc_o,
    output logic           gecerli_o,
    output logic           hata_o
);

    amb_pkg::kontrol_t kontrol;
    amb_pkg::veri_t    ivedi;
    logic              imm_kullan;
    logic              pc_kullan;
    logic              gecersiz;
    amb_pkg::veri_t    deger1;
    amb_pkg::veri_t    deger2;
    amb_pkg::veri_t    amb_sonuc;

    amb_kod_cozucu kod_cozucu_i (
        .buyruk_i     (buyruk_i),
        .kontrol_o    (kontrol),
        .ivedi_o      (ivedi),
        .imm_kullan_o (imm_kullan),
        .pc_kullan_o  (pc_kullan),
        .gecersiz_o   (gecersiz)
    );

    // Operand muxes
    assign deger1 = pc_kullan  ? pc_i  : rs1_i;  // AUIPC
    assign deger2 = imm_kullan ? ivedi : rs2_i;

    aritmetik_mantik_birimi amb_i (
        .kontrol_i (kontrol),
        .deger1_i  (deger1),
        .deger2_i  (deger2),
        .sonuc_o   (amb_sonuc)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gecerli_o <= 1'b0;
            hata_o    <= 1'b0;
            sonuc_o   <= '0;
        end else begin
            gecerli_o <= gecerli_i;
            hata_o    <= gecerli_i & gecersiz;
            if (gecerli_i) begin
                sonuc_o <= gecersiz ? '0 : amb_sonuc;  // Held until the next strobe
            end
        end
    end

    // One cycle latency, also for back-to-back strobes
    a_gecerli_gecikme: assert property (@(posedge clk_i) disable iff (rst_i)
        1'b1 |=> (gecerli_o == $past(gecerli_i)));

    a_hata_gecerli: assert property (@(posedge clk_i) disable iff (rst_i)
        hata_o |-> gecerli_o);

    // Decoder must give a known code whenever the strobe samples it
    a_kontrol_bilinen: assert property (@(posedge clk_i) disable iff (rst_i)
        gecerli_i |-> !$isunknown(kontrol));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_yurut_birimi
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module "$TOP" --Mdir "$OBJ_DIR" -o sim_yurut \
    -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/sim_yurut" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Result: fail"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Result: no pass line in $LOG"
    exit 1
fi
echo "Result: pass"
exit 0
